/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = spiBlockTb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* all.f */
+incdir+rtl
rtl/spiPkg.sv
rtl/spiCsr.sv
rtl/spiClockGen.sv
rtl/spiUnit.sv
rtl/spiBlock.sv
verification/spiFlashModel.sv
verification/spiBlockTb.sv

/* rtl/spiBlock.sv */
`timescale 1ns/1ps
`include "spiBlock_settings.svh"

module spiBlock
(
	input  logic               iSysClk,
	input  logic               arstN,
	input  spiPkg::usiSlaveWr  slaveWr,     // Register access
	output spiPkg::usiSlaveRd  slaveRd,
	output spiPkg::usiMasterWr masterWr,    // Read data to the bus
	output logic               monopoly,
	output spiPkg::spiPins     pins,
	input  logic               miso
);

//----------------------------------------------------------------------
// Internal links
//----------------------------------------------------------------------
spiPkg::spiCfg cfg;
logic          start;
logic          finish;
logic          run;
logic          sck;
logic          riseTick;
logic          fallTick;

// Register file
spiCsr uCsr
(
	.iSysClk (iSysClk),
	.arstN   (arstN),
	.slaveWr (slaveWr),
	.slaveRd (slaveRd),
	.cfg     (cfg),
	.start   (start),
	.finish  (finish)
);

// SCK divider
spiClockGen uClockGen
(
	.iSysClk  (iSysClk),
	.arstN    (arstN),
	.run      (run),
	.div      (cfg.div),
	.sck      (sck),
	.riseTick (riseTick),
	.fallTick (fallTick)
);

// Sequencer and bus master
spiUnit uUnit
(
	.iSysClk  (iSysClk),
	.arstN    (arstN),
	.cfg      (cfg),
	.start    (start),
	.finish   (finish),
	.run      (run),
	.sck      (sck),
	.riseTick (riseTick),
	.fallTick (fallTick),
	.pins     (pins),
	.miso     (miso),
	.masterWr (masterWr),
	.monopoly (monopoly)
);

endmodule

/* rtl/spiBlock_settings.svh */
`ifndef SPI_BLOCK_SETTINGS_SVH
`define SPI_BLOCK_SETTINGS_SVH

// USI bus geometry
`define SPI_BUS_ADRS_BIT    16      // Bus address width
`define SPI_BLOCK_ADRS_MAP  8       // Block select field at top of address
`define SPI_BLOCK_ID        8'h03   // Our block select value

// Register widths
`define SPI_DIV_BIT         16      // SCK divider
`define SPI_LEN_BIT         12      // Byte count

// Register offsets in the low address field
`define SPI_REG_CTRL        0
`define SPI_REG_DIV         1
`define SPI_REG_ADRS        2
`define SPI_REG_LEN         3
`define SPI_REG_DEST        4

`define SPI_READ_CMD        8'h03   // Flash read opcode

`endif

/* rtl/spiClockGen.sv */
`timescale 1ns/1ps
`include "spiBlock_settings.svh"

module spiClockGen
(
	input  logic                    iSysClk,
	input  logic                    arstN,
	input  logic                    run,        // Low holds SCK idle
	input  logic [`SPI_DIV_BIT-1:0] div,        // Half period minus one
	output logic                    sck,
	output logic                    riseTick,   // SCK goes high at next edge
	output logic                    fallTick    // SCK goes low at next edge
);

logic [`SPI_DIV_BIT-1:0] cnt;      // Down counter
logic                    sckReg;
logic                    expire;

assign expire   = run && (cnt == '0);
assign riseTick = expire && !sckReg;
assign fallTick = expire && sckReg;
assign sck      = sckReg;

always_ff @(posedge iSysClk or negedge arstN)
begin
	if (!arstN)
	begin
		cnt    <= '0;
		sckReg <= 1'b0;
	end
	else if (!run)
	begin
		cnt    <= div;      // Preload so first edge is div+1 clocks out
		sckReg <= 1'b0;
	end
	else if (expire)
	begin
		cnt    <= div;
		sckReg <= !sckReg;
	end
	else
	begin
		cnt <= cnt - `SPI_DIV_BIT'(1);
	end
end

endmodule

/* rtl/spiCsr.sv */
`timescale 1ns/1ps
`include "spiBlock_settings.svh"

module spiCsr
(
	input  logic              iSysClk,
	input  logic              arstN,
	input  spiPkg::usiSlaveWr slaveWr,
	output spiPkg::usiSlaveRd slaveRd,
	output spiPkg::spiCfg     cfg,
	output logic              start,     // One cycle kick to the unit
	input  logic              finish     // One cycle from the unit
);

localparam int REG_SEL_BIT = `SPI_BUS_ADRS_BIT - `SPI_BLOCK_ADRS_MAP;

//----------------------------------------------------------------------
// Address decode
//----------------------------------------------------------------------
logic                   blockHit;
logic [REG_SEL_BIT-1:0] regSel;
logic                   wrEn;
logic                   rdEn;
logic                   busy;
logic                   done;
logic [31:0]            rdData;

assign blockHit = (slaveWr.adrs[`SPI_BUS_ADRS_BIT-1 -: `SPI_BLOCK_ADRS_MAP] == `SPI_BLOCK_ID);
assign regSel   = slaveWr.adrs[REG_SEL_BIT-1:0];   // Register offset
assign wrEn     = blockHit && slaveWr.wCke;
assign rdEn     = blockHit && !slaveWr.wCke;      // Any matching non-write is a read

//----------------------------------------------------------------------
// Register file
//----------------------------------------------------------------------
always_ff @(posedge iSysClk or negedge arstN)
begin
	if (!arstN)
	begin
		cfg   <= '0;
		busy  <= 1'b0;
		done  <= 1'b0;
		start <= 1'b0;
	end
	else
	begin
		start <= 1'b0;                      // Pulse only
		if (finish)
		begin
			busy <= 1'b0;
			done <= 1'b1;
		end
		if (wrEn)
		begin
			case (regSel)
				`SPI_REG_CTRL:
				begin
					done <= 1'b0;                   // Any CTRL write clears done
					if (slaveWr.wd[0] && !busy)     // Start while busy is dropped
					begin
						start <= 1'b1;
						busy  <= 1'b1;
					end
				end
				`SPI_REG_DIV:  cfg.div        <= slaveWr.wd[`SPI_DIV_BIT-1:0];
				`SPI_REG_ADRS: cfg.deviceAdrs <= slaveWr.wd[23:0];
				`SPI_REG_LEN:  cfg.negLength  <= slaveWr.wd[`SPI_LEN_BIT-1:0];
				`SPI_REG_DEST: cfg.destAdrs   <= slaveWr.wd[`SPI_BUS_ADRS_BIT-1:0];
				default: ;                          // Unmapped offset
			endcase
		end
	end
end

// Readback mux
always_comb
begin
	case (regSel)
		`SPI_REG_CTRL: rdData = {30'd0, done, busy};
		`SPI_REG_DIV:  rdData = 32'(cfg.div);
		`SPI_REG_ADRS: rdData = 32'(cfg.deviceAdrs);
		`SPI_REG_LEN:  rdData = 32'(cfg.negLength);
		`SPI_REG_DEST: rdData = 32'(cfg.destAdrs);
		default:       rdData = 32'd0;
	endcase
end

// Registered response, zero when not addressed
always_ff @(posedge iSysClk or negedge arstN)
begin
	if (!arstN)
	begin
		slaveRd <= '0;
	end
	else
	begin
		slaveRd.vd <= rdEn;
		slaveRd.rd <= rdEn ? rdData : 32'd0;
	end
end

endmodule

/* rtl/spiPkg.sv */
`include "spiBlock_settings.svh"

package spiPkg;

	// USI bus master to this slave
	typedef struct packed
	{
		logic [31:0]                  wd;     // Write data
		logic [`SPI_BUS_ADRS_BIT-1:0] adrs;
		logic                         wCke;   // Write strobe
	} usiSlaveWr;

	// Slave readback
	typedef struct packed
	{
		logic [31:0] rd;
		logic        vd;                      // Readback valid
	} usiSlaveRd;

	// Master write issued by the sequencer
	typedef struct packed
	{
		logic [31:0]                  wd;
		logic [`SPI_BUS_ADRS_BIT-1:0] adrs;
		logic                         wEd;    // One cycle per word
	} usiMasterWr;

	// Transfer settings from the register file
	typedef struct packed
	{
		logic [`SPI_DIV_BIT-1:0]      div;
		logic [23:0]                  deviceAdrs;   // Flash byte address
		logic [`SPI_LEN_BIT-1:0]      negLength;    // Bytes to read
		logic [`SPI_BUS_ADRS_BIT-1:0] destAdrs;     // First bus write address
	} spiCfg;

	// Serial pins toward the flash
	typedef struct packed
	{
		logic sck;
		logic mosi;
		logic cs;     // Active low
	} spiPins;

endpackage

/* rtl/spiUnit.sv */
`timescale 1ns/1ps
`include "spiBlock_settings.svh"

module spiUnit
(
	input  logic               iSysClk,
	input  logic               arstN,
	input  spiPkg::spiCfg      cfg,
	input  logic               start,
	output logic               finish,
	output logic               run,        // Enables the SCK generator
	input  logic               sck,
	input  logic               riseTick,
	input  logic               fallTick,
	output spiPkg::spiPins     pins,
	input  logic               miso,
	output spiPkg::usiMasterWr masterWr,
	output logic               monopoly    // Bus ownership
);

typedef enum logic [1:0] {stIdle, stCmd, stData, stEnd} stateT;

stateT                        state;
logic [31:0]                  shiftReg;   // Opcode and address out
logic [4:0]                   bitCnt;
logic [6:0]                   byteShift;  // Partial incoming byte
logic [`SPI_LEN_BIT-1:0]      byteCnt;
logic [`SPI_LEN_BIT-1:0]      lenReg;     // Length latched at start
logic [31:0]                  wordAcc;
logic [31:0]                  packWord;
logic [31:0]                  wrData;
logic [`SPI_BUS_ADRS_BIT-1:0] wrAdrs;
logic                         wrEd;
logic                         lastByte;

assign lastByte = ((byteCnt + `SPI_LEN_BIT'(1)) == lenReg);

// Little endian packing, first byte of a word clears the rest
always_comb
begin
	packWord = (byteCnt[1:0] == 2'd0) ? 32'd0 : wordAcc;
	packWord[{byteCnt[1:0], 3'b000} +: 8] = {byteShift, miso};
end

//----------------------------------------------------------------------
// Transfer sequencer
//----------------------------------------------------------------------
always_ff @(posedge iSysClk or negedge arstN)
begin
	if (!arstN)
	begin
		state     <= stIdle;
		shiftReg  <= '0;
		bitCnt    <= '0;
		byteShift <= '0;
		byteCnt   <= '0;
		lenReg    <= '0;
		wordAcc   <= '0;
		wrData    <= '0;
		wrAdrs    <= '0;
		wrEd      <= 1'b0;
	end
	else
	begin
		wrEd <= 1'b0;
		if (wrEd)
			wrAdrs <= wrAdrs + `SPI_BUS_ADRS_BIT'(4);   // Next word slot
		case (state)
			stIdle:
			begin
				if (start)
				begin
					state    <= stCmd;
					shiftReg <= {`SPI_READ_CMD, cfg.deviceAdrs};  // MSB out first
					bitCnt   <= '0;
					byteCnt  <= '0;
					lenReg   <= cfg.negLength;
					wrAdrs   <= cfg.destAdrs;
				end
			end
			stCmd:
			begin
				if (fallTick)                                 // Flash sampled on rise
				begin
					shiftReg <= {shiftReg[30:0], 1'b0};       // Empties to zero
					bitCnt   <= bitCnt + 5'd1;
					if (bitCnt == 5'd31)                      // 32nd fall
						state <= (lenReg == '0) ? stEnd : stData;
				end
			end
			stData:
			begin
				if (riseTick)
				begin
					byteShift <= {byteShift[5:0], miso};
					bitCnt    <= bitCnt + 5'd1;
					if (bitCnt[2:0] == 3'd7)                  // Byte complete
					begin
						byteCnt <= byteCnt + `SPI_LEN_BIT'(1);
						wordAcc <= packWord;
						if ((byteCnt[1:0] == 2'd3) || lastByte)
						begin
							wrEd   <= 1'b1;
							wrData <= packWord;
						end
						if (lastByte)
							state <= stEnd;
					end
				end
			end
			default:
				state <= stIdle;                              // stEnd lasts one cycle
		endcase
	end
end

assign run      = (state == stCmd) || (state == stData);
assign finish   = (state == stEnd);
assign monopoly = start || (state != stIdle);

assign pins.sck  = sck;
assign pins.mosi = shiftReg[31];
assign pins.cs   = (state == stIdle);   // Low for whole transfer

assign masterWr.wd   = wrData;
assign masterWr.adrs = wrAdrs;
assign masterWr.wEd  = wrEd;

endmodule

/* verification/spiBlockTb.sv */
`timescale 1ns/1ps
`include "spiBlock_settings.svh"

module spiBlockTb;

localparam int TEST_NUM    = 6;
localparam int CLK_HALF    = 50;
localparam int REG_SEL_BIT = `SPI_BUS_ADRS_BIT - `SPI_BLOCK_ADRS_MAP;

logic                         iSysClk;
logic                         arstN;
spiPkg::usiSlaveWr            slaveWr;
spiPkg::usiSlaveRd            slaveRd;
spiPkg::usiMasterWr           masterWr;
logic                         monopoly;
spiPkg::spiPins               pins;
logic                         miso;
int                           badCmdCount;
logic [23:0]                  flashAdrs;            // Address seen by the flash

// Test list
int                           seed = 39;
logic [23:0]                  flashList [TEST_NUM];
int                           lenList   [TEST_NUM];
int                           divList   [TEST_NUM];
logic [`SPI_BUS_ADRS_BIT-1:0] destList  [TEST_NUM];
int                           watchdogCycles;
logic                         planReady = 1'b0;

// Scoreboard state
int                           errorCount = 0;
int                           cycleCnt   = 0;
logic                         rdPending;            // Read address on the bus
logic                         rdCheck    = 1'b0;    // Its response is due
logic                         expVd;
logic [31:0]                  expRd;
logic [23:0]                  curFlash;
int                           curLen;
int                           curDiv;
logic [`SPI_BUS_ADRS_BIT-1:0] curDest;
int                           expCount;             // Word writes per transfer
int                           wrSeen     = 0;
int                           wordStart;
int                           wordIdx;
logic [31:0]                  expWord;
logic [`SPI_BUS_ADRS_BIT-1:0] expAdrs;
logic                         monoPrev   = 1'b0;
logic                         idleExpected;
logic                         sckPrev    = 1'b0;
int                           runLen     = 0;       // Clocks since last SCK edge
int                           edgesSeen  = 0;
logic                         gapDone    = 1'b0;
int                           gapLen     = 0;

spiBlock DUT
(
	.iSysClk  (iSysClk),
	.arstN    (arstN),
	.slaveWr  (slaveWr),
	.slaveRd  (slaveRd),
	.masterWr (masterWr),
	.monopoly (monopoly),
	.pins     (pins),
	.miso     (miso)
);

spiFlashModel uFlash
(
	.sck         (pins.sck),
	.mosi        (pins.mosi),
	.cs          (pins.cs),
	.miso        (miso),
	.badCmdCount (badCmdCount),
	.rxAdrs      (flashAdrs)
);

always #CLK_HALF iSysClk = ~iSysClk;

// Flash content rule
function automatic logic [7:0] flashByte(input logic [23:0] base, input int k);
	logic [23:0] a;
	a = base + 24'(k);
	flashByte = a[7:0] ^ 8'hA5;
endfunction

// Little endian word zero padded past the length
function automatic logic [31:0] packedWord(input logic [23:0] base, input int len, input int idx);
	logic [31:0] w;
	int          j;
	w = '0;
	for (j = 0; j < 4; j++)
		if (4 * idx + j < len)
			w[8 * j +: 8] = flashByte(base, 4 * idx + j);
	packedWord = w;
endfunction

always_comb
begin
	wordIdx = wrSeen - wordStart;
	expWord = packedWord(curFlash, curLen, wordIdx);
	expAdrs = curDest + `SPI_BUS_ADRS_BIT'(4 * wordIdx);
end

//----------------------------------------------------------------------
// Edge trackers
//----------------------------------------------------------------------
always @(posedge iSysClk)
begin
	cycleCnt <= cycleCnt + 1;
	rdCheck  <= rdPending;
	monoPrev <= monopoly;
	if (masterWr.wEd)
		wrSeen <= wrSeen + 1;
	sckPrev <= pins.sck;
	gapDone <= 1'b0;
	if (pins.cs)                              // Idle so forget the old edge
	begin
		edgesSeen <= 0;
		runLen    <= 1;
	end
	else if (pins.sck != sckPrev)
	begin
		if (edgesSeen > 0)
		begin
			gapDone <= 1'b1;
			gapLen  <= runLen;
		end
		edgesSeen <= edgesSeen + 1;
		runLen    <= 1;
	end
	else
		runLen <= runLen + 1;
end

//----------------------------------------------------------------------
// Assertions
//----------------------------------------------------------------------
assert property (@(posedge iSysClk) (!arstN && cycleCnt > 0) |-> (pins.cs && !pins.sck
	&& !pins.mosi && !masterWr.wEd && !slaveRd.vd && !monopoly))
else
begin
	errorCount++;
	$display("Mismatch at %0t: outputs not at reset values", $time);
end

assert property (@(posedge iSysClk) disable iff (!arstN)
	rdCheck |-> (slaveRd.vd == expVd && slaveRd.rd == expRd))
else
begin
	errorCount++;
	$display("Mismatch at %0t: readback vd %b data %h, expected vd %b data %h",
		$time, $sampled(slaveRd.vd), $sampled(slaveRd.rd), expVd, expRd);
end

assert property (@(posedge iSysClk) disable iff (!arstN) !rdCheck |-> !slaveRd.vd)
else
begin
	errorCount++;
	$display("Mismatch at %0t: readback valid without a read", $time);
end

assert property (@(posedge iSysClk) disable iff (!arstN)
	masterWr.wEd |-> (wordIdx < expCount))
else
begin
	errorCount++;
	$display("Mismatch at %0t: write %0d exceeds the %0d words expected",
		$time, wordIdx, expCount);
end

assert property (@(posedge iSysClk) disable iff (!arstN)
	masterWr.wEd |-> (masterWr.wd == expWord && masterWr.adrs == expAdrs))
else
begin
	errorCount++;
	$display("Mismatch at %0t: word %0d is %h at %h, expected %h at %h", $time, wordIdx,
		$sampled(masterWr.wd), $sampled(masterWr.adrs), expWord, expAdrs);
end

assert property (@(posedge iSysClk) disable iff (!arstN)
	(masterWr.wEd || !pins.cs) |-> monopoly)
else
begin
	errorCount++;
	$display("Mismatch at %0t: bus write or CS low without monopoly", $time);
end

assert property (@(posedge iSysClk) disable iff (!arstN)
	(monoPrev && !monopoly) |-> (wordIdx == expCount))
else
begin
	errorCount++;
	$display("Mismatch at %0t: %0d words written, expected %0d", $time, wordIdx, expCount);
end

// Full 24 bit address shifted out on MOSI
assert property (@(posedge iSysClk) disable iff (!arstN)
	(monoPrev && !monopoly) |-> (flashAdrs == curFlash))
else
begin
	errorCount++;
	$display("Mismatch at %0t: flash received address %h, expected %h", $time,
		$sampled(flashAdrs), curFlash);
end

assert property (@(posedge iSysClk) disable iff (!arstN)
	idleExpected |-> (pins.cs && !monopoly))
else
begin
	errorCount++;
	$display("Mismatch at %0t: block active while it should be idle", $time);
end

assert property (@(posedge iSysClk) disable iff (!arstN) gapDone |-> (gapLen == curDiv + 1))
else
begin
	errorCount++;
	$display("Mismatch at %0t: SCK half period %0d clocks, expected %0d",
		$time, gapLen, curDiv + 1);
end

//----------------------------------------------------------------------
// Bus tasks entered and left on a falling edge
//----------------------------------------------------------------------
task automatic writeReg(input int offset, input logic [31:0] data);
	slaveWr.adrs = {`SPI_BLOCK_ID, REG_SEL_BIT'(offset)};
	slaveWr.wd   = data;
	slaveWr.wCke = 1'b1;
	@(negedge iSysClk);
	slaveWr = '0;                                 // Block 0 is nobody
endtask

task automatic readReg(input logic [7:0] blockSel, input int offset, input logic vd,
	input logic [31:0] data);
	slaveWr.adrs = {blockSel, REG_SEL_BIT'(offset)};
	slaveWr.wCke = 1'b0;
	expVd        = vd;
	expRd        = data;
	rdPending    = 1'b1;
	@(negedge iSysClk);
	rdPending = 1'b0;
	slaveWr   = '0;
	@(negedge iSysClk);                           // Response checked here
endtask

task automatic planTests();
	int t;
	watchdogCycles = 300;                         // Register phase and slack
	for (t = 0; t < TEST_NUM; t++)
	begin
		flashList[t] = 24'($random(seed));
		destList[t]  = `SPI_BUS_ADRS_BIT'($random(seed)) & ~`SPI_BUS_ADRS_BIT'(3);
		divList[t]   = (t % 2 == 0) ? 1 : 3;          // Two divider values
		case (t)
			0:       lenList[t] = 0;                  // Command only
			1:       lenList[t] = 1 + $unsigned($random(seed)) % 3;
			2:       lenList[t] = 4;
			3:       lenList[t] = 5 + $unsigned($random(seed)) % 12;
			4:       lenList[t] = 1 + $unsigned($random(seed)) % 20;
			default: lenList[t] = 8;
		endcase
		watchdogCycles += 2 * (divList[t] + 1) * (32 + 8 * lenList[t]) + 40;
	end
endtask

task automatic checkRegisters();
	logic [31:0] val [4];
	int          r;
	for (r = 0; r < 5; r++)
		readReg(`SPI_BLOCK_ID, r, 1'b1, 32'd0);       // All clear out of reset
	for (r = 0; r < 4; r++)
		val[r] = $random(seed);
	writeReg(`SPI_REG_DIV, val[0]);
	writeReg(`SPI_REG_ADRS, val[1]);
	writeReg(`SPI_REG_LEN, val[2]);
	writeReg(`SPI_REG_DEST, val[3]);
	readReg(`SPI_BLOCK_ID, `SPI_REG_DIV, 1'b1, val[0] & 32'h0000_FFFF);
	readReg(`SPI_BLOCK_ID, `SPI_REG_ADRS, 1'b1, val[1] & 32'h00FF_FFFF);
	readReg(`SPI_BLOCK_ID, `SPI_REG_LEN, 1'b1, val[2] & 32'h0000_0FFF);
	readReg(`SPI_BLOCK_ID, `SPI_REG_DEST, 1'b1, val[3] & 32'h0000_FFFF);
	readReg(8'h05, `SPI_REG_DIV, 1'b0, 32'd0);        // Foreign block id
endtask

task automatic runTransfer(input int t);
	curFlash  = flashList[t];
	curLen    = lenList[t];
	curDiv    = divList[t];
	curDest   = destList[t];
	expCount  = (lenList[t] + 3) / 4;
	wordStart = wrSeen;
	writeReg(`SPI_REG_DIV, 32'(divList[t]));
	writeReg(`SPI_REG_ADRS, 32'(flashList[t]));
	writeReg(`SPI_REG_LEN, 32'(lenList[t]));
	writeReg(`SPI_REG_DEST, 32'(destList[t]));
	idleExpected = 1'b0;
	writeReg(`SPI_REG_CTRL, 32'h1);
	writeReg(`SPI_REG_CTRL, 32'h1);               // Second start while busy is dropped
	readReg(`SPI_BLOCK_ID, `SPI_REG_CTRL, 1'b1, 32'h1);
	while (monopoly)
		@(negedge iSysClk);
	idleExpected = 1'b1;
	readReg(`SPI_BLOCK_ID, `SPI_REG_CTRL, 1'b1, 32'h2);   // Done and idle
endtask

// Watchdog
initial
begin
	wait (planReady);
	repeat (watchdogCycles) @(posedge iSysClk);
	$display("Watchdog expired after %0d cycles before the transfers completed",
		watchdogCycles);
	$display("TEST FAILED");
	$finish;
end

initial
begin
	iSysClk      = 1'b0;
	arstN        = 1'b0;
	slaveWr      = '0;
	rdPending    = 1'b0;
	expVd        = 1'b0;
	expRd        = '0;
	idleExpected = 1'b1;
	curFlash     = '0;
	curLen       = 0;
	curDiv       = 0;
	curDest      = '0;
	expCount     = 0;
	wordStart    = 0;
	planTests();
	planReady = 1'b1;
	repeat (8) @(negedge iSysClk);
	arstN = 1'b1;
	@(negedge iSysClk);
	checkRegisters();
	for (int t = 0; t < TEST_NUM; t++)
		runTransfer(t);
	repeat (4) @(negedge iSysClk);
	$display("Errors: %0d mismatches, %0d flash command errors", errorCount, badCmdCount);
	if (errorCount == 0 && badCmdCount == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

/* verification/spiFlashModel.sv */
`timescale 1ns/1ps
`include "spiBlock_settings.svh"

module spiFlashModel
(
	input  logic        sck,
	input  logic        mosi,
	input  logic        cs,            // Active low select
	output logic        miso,
	output int          badCmdCount,   // Opcodes other than read
	output logic [23:0] rxAdrs         // Address taken in the last frame
);

logic [31:0] cmdAdrs;           // Opcode then 24 bit address
int          inCnt;             // Bits shifted in this frame
int          outCnt;            // Data bits driven so far
logic [23:0] byteAdrs;
logic [7:0]  dataByte;

assign rxAdrs = cmdAdrs[23:0];

initial
begin
	miso        = 1'b0;
	badCmdCount = 0;
	cmdAdrs     = '0;
	inCnt       = 0;
	outCnt      = 0;
end

// New frame
always @(negedge cs)
begin
	inCnt  = 0;
	outCnt = 0;
end

// Command and address taken on the rise
always @(posedge sck)
begin
	if (!cs && inCnt < 32)
	begin
		cmdAdrs = {cmdAdrs[30:0], mosi};   // MSB first
		inCnt   = inCnt + 1;
	end
end

//----------------------------------------------------------------------
// Read data launched on the fall after the 32nd bit
//----------------------------------------------------------------------
always @(negedge sck)
begin
	if (!cs && inCnt == 32)
	begin
		if (outCnt == 0)
		begin
			assert (cmdAdrs[31:24] == `SPI_READ_CMD)
			else
			begin
				badCmdCount++;
				$display("Flash model received command %h, which is not a read, at %0t",
					cmdAdrs[31:24], $time);
			end
		end
		byteAdrs = cmdAdrs[23:0] + 24'(outCnt / 8);   // Address steps per byte
		dataByte = byteAdrs[7:0] ^ 8'hA5;
		miso     = dataByte[3'(7 - (outCnt % 8))];
		outCnt   = outCnt + 1;
	end
end

endmodule
